//--- sources.f
+incdir+.
daqPkg.sv
commandDecoder.sv
trigCoincid.sv
holdGen.sv
eventRecorder.sv
daqTop.sv
tbDaqTop.sv

//--- Bender.yml
package:
  name: daq_trigger_hold

sources:
  - include_dirs:
      - .
    files:
      - daqPkg.sv
      - commandDecoder.sv
      - trigCoincid.sv
      - holdGen.sv
      - eventRecorder.sv
      - daqTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbDaqTop.sv

//--- tbDaqTop.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module tbDaqTop;

    localparam int WAIT_LIMIT = 64; // Cycles allowed for any HOLD edge

    logic                Clk;
    logic                rst;
    daqPkg::cmdWord_t    cmdWord;
    logic                cmdValid;
    logic [3:0]          pinsB;        // {EXT, TRIG2, TRIG1, TRIG0}, active low
    logic                hold;
    logic                triggerOut;
    daqPkg::eventWord_t  eventWord;
    logic                eventValid;

    // Model state
    logic [31:0]         rngState;
    daqPkg::trigMode_t   curMode;
    logic                holdEnModel;
    int                  curDelay;
    int                  curTime;
    daqPkg::header_t     expHeader;
    daqPkg::eventCount_t expCount;
    daqPkg::eventWord_t  expQ[$];      // Records still to arrive
    daqPkg::eventWord_t  expWord;
    int                  trigSeen;
    int                  holdSeen;
    logic                holdPrevSeen;

    daqTop u_daqTop (
        .Clk         (Clk),
        .rst         (rst),
        .cmdWord     (cmdWord),
        .cmdValid    (cmdValid),
        .OUT_TRIG0B  (pinsB[0]),
        .OUT_TRIG1B  (pinsB[1]),
        .OUT_TRIG2B  (pinsB[2]),
        .EXT_TRIGB   (pinsB[3]),
        .HOLD        (hold),
        .TRIGGER_OUT (triggerOut),
        .eventWord   (eventWord),
        .eventValid  (eventValid)
    );

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk; // 100 MHz
    end

    ////////////////////
    // Helpers
    ////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // Trigger condition from mode and active-low pin levels
    function automatic logic trigCondition(input daqPkg::trigMode_t mode, input logic [3:0] pb);
        case (mode)
            daqPkg::TRIG_OR:     return !pb[0] || !pb[1] || !pb[2];
            daqPkg::TRIG_AND:    return !pb[0] && !pb[1] && !pb[2];
            daqPkg::TRIG_SINGLE: return !pb[0];
            default:             return !pb[3];  // External pin
        endcase
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkValue(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            failRun($sformatf("Error at %0t ns: %s is 0x%0h, expected 0x%0h",
                              $time, what, got, exp));
        end
    endtask

    task automatic sendCmd(input logic [3:0] addr, input logic [11:0] data);
        @(posedge Clk);
        cmdWord  <= {addr, data};
        cmdValid <= 1'b1;   // Single-cycle strobe
        @(posedge Clk);
        cmdValid <= 1'b0;
    endtask

    task automatic setMode(input daqPkg::trigMode_t mode);
        sendCmd(`DAQ_ADDR_TRIGMODE, {10'd0, mode});
        curMode = mode;
    endtask

    task automatic setHoldTiming(input int delay, input int len);
        sendCmd(`DAQ_ADDR_HOLDDELAY, 12'(delay));
        sendCmd(`DAQ_ADDR_HOLDTIME, 12'(len));
        curDelay = delay;
        curTime  = len;
    endtask

    task automatic applyPins(input logic [3:0] pb);
        @(posedge Clk);
        pinsB <= pb;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge Clk);
    endtask

    // Counts low negedges before HOLD reaches level
    task automatic waitHold(input logic level, output int cycles);
        cycles = 0;
        @(negedge Clk);
        while (hold !== level) begin
            if (cycles >= WAIT_LIMIT) begin
                failRun($sformatf("Timeout: HOLD did not go to %0b within %0d cycles",
                                  level, WAIT_LIMIT));
            end
            cycles++;
            @(negedge Clk);
        end
    endtask

    task automatic runTrial(input logic [3:0] pb);
        int   trigBefore;
        int   holdBefore;
        int   cycles;
        logic cond;
        logic hit;
        cond       = trigCondition(curMode, pb);
        hit        = cond && holdEnModel;
        trigBefore = trigSeen;
        holdBefore = holdSeen;
        if (hit) begin
            expQ.push_back({expHeader, expCount});
            expCount++; // Wraps with the type
        end
        applyPins(pb);
        if (hit) begin
            waitHold(1'b1, cycles);
            checkValue(cycles, curDelay + 4, "pin to HOLD latency");
            waitHold(1'b0, cycles);
            checkValue(cycles + 1, curTime, "HOLD length"); // First high cycle already seen
        end else begin
            idle(curDelay + curTime + 10);
        end
        applyPins(4'hF);
        idle(8);
        checkValue(trigSeen - trigBefore, cond, "trigger pulses");
        checkValue(holdSeen - holdBefore, hit, "holds");
        checkValue(expQ.size(), 0, "records outstanding");
    endtask

    // Second edge lands inside HOLD and must be dropped
    task automatic runBusyTrial;
        int trigBefore;
        int holdBefore;
        int cycles;
        trigBefore = trigSeen;
        holdBefore = holdSeen;
        expQ.push_back({expHeader, expCount});
        expCount++;
        applyPins(4'b1110);
        waitHold(1'b1, cycles);
        applyPins(4'hF);
        idle(2);
        applyPins(4'b1110);
        waitHold(1'b0, cycles);
        applyPins(4'hF);
        idle(curDelay + curTime + 10);
        checkValue(trigSeen - trigBefore, 2, "trigger pulses in busy period");
        checkValue(holdSeen - holdBefore, 1, "holds in busy period");
        checkValue(expQ.size(), 0, "records outstanding");
    endtask

    ////////////////////
    // Compare process
    ////////////////////
    always @(negedge Clk) begin
        if (rst) begin
            trigSeen     = 0;
            holdSeen     = 0;
            holdPrevSeen = 1'b0;
        end else begin
            if (triggerOut) trigSeen++;
            if (hold && !holdPrevSeen) holdSeen++;
            holdPrevSeen = hold;
            if (eventValid) begin
                if (expQ.size() == 0) begin
                    failRun("A record arrived when no hold was expected");
                end else begin
                    expWord = expQ.pop_front();
                    checkValue(eventWord, expWord, "event record");
                end
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////
    initial begin
        int i;
        rngState    = 32'h18c1_a97f;
        rst         = 1'b1;
        cmdWord     = '0;
        cmdValid    = 1'b0;
        pinsB       = 4'hF;  // Pins idle high
        curMode     = daqPkg::TRIG_OR;
        holdEnModel = 1'b1;
        curDelay    = `DAQ_DEF_HOLDDELAY;
        curTime     = `DAQ_DEF_HOLDTIME;
        expHeader   = `DAQ_DEF_HEADER;
        expCount    = '0;
        repeat (5) @(posedge Clk);
        rst <= 1'b0;

        for (i = 0; i < 20; i++) begin // Quiet outputs after reset
            @(negedge Clk);
            checkValue({hold, triggerOut, eventValid}, 3'b000, "outputs after reset");
        end

        setMode(daqPkg::TRIG_AND);
        runTrial(4'b1110);   // One line low, no coincidence
        runTrial(4'b1000);   // All three low
        setMode(daqPkg::TRIG_OR);
        runTrial(4'b1101);

        // Random modes, patterns and timing
        for (i = 0; i < 48; i++) begin
            if (i % 4 == 0) begin
                rngState = xorshift32(rngState);
                setHoldTiming(rngState[3:0], 1 + rngState[15:8] % 20);
            end
            rngState = xorshift32(rngState);
            setMode(daqPkg::trigMode_t'(rngState[1:0]));
            rngState = xorshift32(rngState);
            runTrial(rngState[3:0]);
        end

        setMode(daqPkg::TRIG_OR);
        setHoldTiming(2, 20);
        runBusyTrial;

        sendCmd(`DAQ_ADDR_HOLDEN, 12'd0);
        holdEnModel = 1'b0;
        runTrial(4'b1110);   // Pulse only
        sendCmd(`DAQ_ADDR_HOLDEN, 12'd1);
        holdEnModel = 1'b1;

        sendCmd(4'hF, 12'hFFF); // Unknown addresses
        sendCmd(4'h0, 12'h0FF);
        runTrial(4'b1110);

        // New header, then count past 255 and clear
        rngState = xorshift32(rngState);
        sendCmd(`DAQ_ADDR_HEADER, {4'd0, rngState[7:0]});
        expHeader = rngState[7:0];
        setHoldTiming(0, 1);
        setMode(daqPkg::TRIG_SINGLE);
        for (i = 0; i < 260; i++) begin
            runTrial(4'b1110);
        end
        sendCmd(`DAQ_ADDR_CNTCLR, 12'd0);
        expCount = '0;
        runTrial(4'b1110);

        if (expQ.size() != 0) begin
            failRun("Run ended with expected records that never arrived");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- daqTop.sv
`timescale 1ns/10ps

module daqTop (
    input  logic               Clk,
    input  logic               rst,
    // Host control
    input  daqPkg::cmdWord_t   cmdWord,
    input  logic               cmdValid,
    // ASIC and external trigger pins
    input  logic               OUT_TRIG0B,
    input  logic               OUT_TRIG1B,
    input  logic               OUT_TRIG2B,
    input  logic               EXT_TRIGB,
    // Outputs
    output logic               HOLD,
    output logic               TRIGGER_OUT,
    output daqPkg::eventWord_t eventWord,
    output logic               eventValid
);

    daqPkg::trigMode_t  trigMode;
    logic               holdEn;
    daqPkg::holdDelay_t holdDelay;
    daqPkg::holdTime_t  holdTime;
    daqPkg::header_t    header;
    logic               cntClr;
    logic               trigPulse;

    ////////////////////
    // Configuration
    ////////////////////
    commandDecoder u_commandDecoder (
        .Clk       (Clk),
        .rst       (rst),
        .cmdWord   (cmdWord),
        .cmdValid  (cmdValid),
        .trigMode  (trigMode),
        .holdEn    (holdEn),
        .holdDelay (holdDelay),
        .holdTime  (holdTime),
        .header    (header),
        .cntClr    (cntClr)
    );

    ////////////////////
    // Trigger and hold
    ////////////////////
    trigCoincid u_trigCoincid (
        .Clk        (Clk),
        .rst        (rst),
        .OUT_TRIG0B (OUT_TRIG0B),
        .OUT_TRIG1B (OUT_TRIG1B),
        .OUT_TRIG2B (OUT_TRIG2B),
        .EXT_TRIGB  (EXT_TRIGB),
        .trigMode   (trigMode),
        .trigPulse  (trigPulse)
    );

    assign TRIGGER_OUT = trigPulse; // Selected trigger to the pin

    holdGen u_holdGen (
        .Clk       (Clk),
        .rst       (rst),
        .trigPulse (trigPulse),
        .holdEn    (holdEn),
        .holdDelay (holdDelay),
        .holdTime  (holdTime),
        .HOLD      (HOLD)
    );

    // Records, one per HOLD rise
    eventRecorder u_eventRecorder (
        .Clk        (Clk),
        .rst        (rst),
        .HOLD       (HOLD),
        .header     (header),
        .cntClr     (cntClr),
        .eventWord  (eventWord),
        .eventValid (eventValid)
    );

endmodule

//--- eventRecorder.sv
`timescale 1ns/10ps

module eventRecorder (
    input  logic               Clk,
    input  logic               rst,
    input  logic               HOLD,
    input  daqPkg::header_t    header,
    input  logic               cntClr,
    output daqPkg::eventWord_t eventWord,
    output logic               eventValid  // One cycle per hold
);

    logic                holdPrev;
    logic                holdRise;
    daqPkg::eventCount_t eventCount;

    assign holdRise = HOLD & ~holdPrev;

    // Strobe and counter
    always_ff @(posedge Clk) begin
        if (rst) begin
            holdPrev   <= 1'b0;
            eventValid <= 1'b0;
            eventCount <= '0;
        end else begin
            holdPrev   <= HOLD;
            eventValid <= holdRise;
            if (cntClr) begin
                eventCount <= '0; // Clear beats the increment
            end else if (holdRise) begin
                eventCount <= eventCount + 1'b1; // Wraps at 255
            end
        end
    end

    // Record payload keeps the old count on a clear
    always_ff @(posedge Clk) begin
        if (holdRise) begin
            eventWord <= {header, eventCount};
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    assert property (@(posedge Clk) disable iff (rst)
        eventValid |=> !eventValid)
        else $error("eventValid longer than one cycle");

endmodule

//--- holdGen.sv
`timescale 1ns/10ps

module holdGen (
    input  logic               Clk,
    input  logic               rst,
    input  logic               trigPulse,
    input  logic               holdEn,
    input  daqPkg::holdDelay_t holdDelay,
    input  daqPkg::holdTime_t  holdTime,
    output logic               HOLD
);

    daqPkg::holdState_t state;
    daqPkg::holdTime_t  cnt;      // Shared down-counter, delay then length
    daqPkg::holdTime_t  holdLen;  // Length frozen at acceptance
    logic               accept;

    // Index of the last HOLD cycle, zero length acts as one
    function automatic daqPkg::holdTime_t lastCycle(input daqPkg::holdTime_t len);
        lastCycle = (len == '0) ? '0 : len - 1'b1;
    endfunction

    // Only idle triggers count
    assign accept = (state == daqPkg::HOLD_IDLE) && trigPulse && holdEn;

    always_ff @(posedge Clk) begin
        if (accept) begin
            holdLen <= holdTime;
        end
    end

    ////////////////////
    // Hold FSM
    ////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            state <= daqPkg::HOLD_IDLE;
            cnt   <= '0;
            HOLD  <= 1'b0;
        end else begin
            case (state)
                daqPkg::HOLD_IDLE: begin
                    if (accept) begin
                        if (holdDelay == '0) begin // Straight to HOLD
                            state <= daqPkg::HOLD_ACTIVE;
                            HOLD  <= 1'b1;
                            cnt   <= lastCycle(holdTime);
                        end else begin
                            state <= daqPkg::HOLD_DELAY;
                            cnt   <= daqPkg::holdTime_t'(holdDelay) - 1'b1;
                        end
                    end
                end
                daqPkg::HOLD_DELAY: begin
                    if (cnt == '0) begin
                        state <= daqPkg::HOLD_ACTIVE;
                        HOLD  <= 1'b1;
                        cnt   <= lastCycle(holdLen);
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                daqPkg::HOLD_ACTIVE: begin
                    if (cnt == '0) begin
                        state <= daqPkg::HOLD_IDLE; // Ready on the same edge HOLD drops
                        HOLD  <= 1'b0;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: begin
                    state <= daqPkg::HOLD_IDLE;
                    HOLD  <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////
    // Checks
    ////////////////////
    assert property (@(posedge Clk) disable iff (rst)
        (state == daqPkg::HOLD_IDLE) |-> !HOLD)
        else $error("HOLD high while idle");

    // Disabled path must not leave idle on a trigger
    assert property (@(posedge Clk) disable iff (rst)
        (state == daqPkg::HOLD_IDLE && trigPulse && !holdEn) |=>
        (state == daqPkg::HOLD_IDLE))
        else $error("hold started with holdEn low");

endmodule

//--- trigCoincid.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module trigCoincid (
    input  logic              Clk,
    input  logic              rst,
    input  logic              OUT_TRIG0B,  // ASIC triggers, async, active low
    input  logic              OUT_TRIG1B,
    input  logic              OUT_TRIG2B,
    input  logic              EXT_TRIGB,   // External pin, async, active low
    input  daqPkg::trigMode_t trigMode,
    output logic              trigPulse    // One cycle per rising condition
);

    logic [3:0]                             pinRaw;
    logic [`DAQ_SYNC_STAGES-1:0][3:0]       syncPipe;
    logic [3:0]                             trigLvl;   // Active high after sync
    logic                                   trigOr;
    logic                                   trigAnd;
    logic                                   selLvl;
    logic                                   selPrev;

    // Bit 3 external, bits 2..0 ASIC lines
    assign pinRaw = {EXT_TRIGB, OUT_TRIG2B, OUT_TRIG1B, OUT_TRIG0B};

    ////////////////////
    // Synchroniser
    ////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            syncPipe <= '1; // Idle level of the pins
        end else begin
            syncPipe <= {syncPipe[`DAQ_SYNC_STAGES-2:0], pinRaw};
        end
    end

    assign trigLvl = ~syncPipe[`DAQ_SYNC_STAGES-1];

    // Coincidence terms
    assign trigOr  = |trigLvl[2:0];
    assign trigAnd = &trigLvl[2:0];

    always_comb begin
        selLvl = 1'b0;
        case (trigMode)
            daqPkg::TRIG_OR:     selLvl = trigOr;
            daqPkg::TRIG_AND:    selLvl = trigAnd;
            daqPkg::TRIG_SINGLE: selLvl = trigLvl[0];
            daqPkg::TRIG_EXT:    selLvl = trigLvl[3];
            default:             selLvl = 1'b0;
        endcase
    end

    ////////////////////
    // Edge detect
    ////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            selPrev   <= 1'b0;
            trigPulse <= 1'b0;
        end else begin
            selPrev   <= selLvl;
            trigPulse <= selLvl & ~selPrev; // Registered rising edge
        end
    end

    // Pulse never stretches
    assert property (@(posedge Clk) disable iff (rst)
        trigPulse |=> !trigPulse)
        else $error("trigPulse high two cycles in a row");

endmodule

//--- commandDecoder.sv
`timescale 1ns/10ps
`include "daq_consts.svh"

module commandDecoder (
    input  logic               Clk,
    input  logic               rst,
    input  daqPkg::cmdWord_t   cmdWord,
    input  logic               cmdValid,   // One cycle per word
    output daqPkg::trigMode_t  trigMode,
    output logic               holdEn,
    output daqPkg::holdDelay_t holdDelay,
    output daqPkg::holdTime_t  holdTime,
    output daqPkg::header_t    header,
    output logic               cntClr      // Single-cycle clear
);

    daqPkg::cmdAddr_t            cmdAddr;
    logic [`DAQ_DATA_WIDTH-1:0]  cmdData;

    // Split the word into its fields
    assign cmdAddr = cmdWord[`DAQ_CMD_WIDTH-1 -: `DAQ_ADDR_WIDTH];
    assign cmdData = cmdWord[`DAQ_DATA_WIDTH-1:0];

    ////////////////////
    // Config registers
    ////////////////////
    always_ff @(posedge Clk) begin
        if (rst) begin
            trigMode  <= daqPkg::TRIG_OR;
            holdEn    <= 1'b1;
            holdDelay <= `DAQ_DEF_HOLDDELAY;
            holdTime  <= `DAQ_DEF_HOLDTIME;
            header    <= `DAQ_DEF_HEADER;
            cntClr    <= 1'b0;
        end else begin
            cntClr <= 1'b0; // Pulses only on its address
            if (cmdValid) begin
                case (cmdAddr)
                    `DAQ_ADDR_TRIGMODE: begin
                        trigMode <= daqPkg::trigMode_t'(cmdData[1:0]);
                    end
                    `DAQ_ADDR_HOLDDELAY: begin
                        holdDelay <= cmdData[`DAQ_HOLDDELAY_WIDTH-1:0];
                    end
                    `DAQ_ADDR_HOLDTIME: begin
                        holdTime <= cmdData[`DAQ_HOLDTIME_WIDTH-1:0]; // Full data field
                    end
                    `DAQ_ADDR_HEADER: begin
                        header <= cmdData[`DAQ_HEADER_WIDTH-1:0];
                    end
                    `DAQ_ADDR_HOLDEN: begin
                        holdEn <= cmdData[0];
                    end
                    `DAQ_ADDR_CNTCLR: begin
                        cntClr <= 1'b1;
                    end
                    default: begin
                        // Unknown address dropped
                    end
                endcase
            end
        end
    end

    ////////////////////
    // Checks
    ////////////////////

    // Clear is a single-cycle strobe
    assert property (@(posedge Clk) disable iff (rst)
        cntClr |=> !cntClr)
        else $error("cntClr held for two cycles");

endmodule

//--- daqPkg.sv
`include "daq_consts.svh"

package daqPkg;

    ////////////////////
    // Command format
    ////////////////////
    typedef logic [`DAQ_CMD_WIDTH-1:0]  cmdWord_t;  // [15:12] addr, [11:0] data
    typedef logic [`DAQ_ADDR_WIDTH-1:0] cmdAddr_t;

    // Trigger source select
    typedef enum logic [1:0] {
        TRIG_OR     = 2'd0, // Any ASIC line
        TRIG_AND    = 2'd1, // All three ASIC lines
        TRIG_SINGLE = 2'd2, // Line 0 alone
        TRIG_EXT    = 2'd3  // External pin
    } trigMode_t;

    ////////////////////
    // Hold path
    ////////////////////
    typedef logic [`DAQ_HOLDDELAY_WIDTH-1:0] holdDelay_t; // Cycles before HOLD
    typedef logic [`DAQ_HOLDTIME_WIDTH-1:0]  holdTime_t;  // Cycles of HOLD

    typedef enum logic [1:0] {
        HOLD_IDLE,
        HOLD_DELAY,
        HOLD_ACTIVE
    } holdState_t;

    // Event record
    typedef logic [`DAQ_HEADER_WIDTH-1:0] header_t;
    typedef logic [`DAQ_COUNT_WIDTH-1:0]  eventCount_t;
    typedef logic [`DAQ_HEADER_WIDTH+`DAQ_COUNT_WIDTH-1:0] eventWord_t; // {header, count}

endpackage

//--- daq_consts.svh
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

// Field widths
`define DAQ_CMD_WIDTH        16   // USB control word
`define DAQ_ADDR_WIDTH       4    // Command address field
`define DAQ_DATA_WIDTH       12   // Command data field
`define DAQ_HOLDDELAY_WIDTH  8
`define DAQ_HOLDTIME_WIDTH   12
`define DAQ_HEADER_WIDTH     8
`define DAQ_COUNT_WIDTH      8    // Event counter, wraps

// Command addresses
`define DAQ_ADDR_TRIGMODE    4'd1
`define DAQ_ADDR_HOLDDELAY   4'd2
`define DAQ_ADDR_HOLDTIME    4'd3
`define DAQ_ADDR_HEADER      4'd4
`define DAQ_ADDR_HOLDEN      4'd5
`define DAQ_ADDR_CNTCLR      4'd6

`define DAQ_SYNC_STAGES      2    // Flops per trigger pin

// Power-up configuration
`define DAQ_DEF_HOLDDELAY    8'd4
`define DAQ_DEF_HOLDTIME     12'd16
`define DAQ_DEF_HEADER       8'h5A

`endif
